// ==== Bender.yml ====
package:
  name: adc_frontend

sources:
  # package first, then the blocks, top level last
  - rtl/adc_pkg.sv
  - rtl/adc_phase_timer.sv
  - rtl/adc_conv_fsm.sv
  - rtl/az_sequencer.sv
  - rtl/az_result_regs.sv
  - rtl/adc_frontend_top.sv

  - target: simulation
    files:
      - verification/tb_adc_frontend.sv

// ==== adc_frontend.f ====
rtl/adc_pkg.sv
rtl/adc_phase_timer.sv
rtl/adc_conv_fsm.sv
rtl/az_sequencer.sv
rtl/az_result_regs.sv
rtl/adc_frontend_top.sv
verification/tb_adc_frontend.sv

// ==== rtl/adc_conv_fsm.sv ====
/* conversion controller: steers the integrator switches through reset,
   signal integration and run-down, restartable by a trigger at any time */

`timescale 1ns/1ps

module adc_conv_fsm (
  input  logic                  clk,
  input  logic                  reset,
  input  adc_pkg::count_t       clk_sample_duration,
  input  logic                  adc_measure_trig,
  input  logic                  cmpr_in,
  input  adc_pkg::count_t       remaining,
  input  logic                  expired,
  output logic                  timer_load,
  output adc_pkg::count_t       timer_value,
  output logic                  cmpr_latch,
  output adc_pkg::refmux_t      refmux,
  output logic                  sigmux,
  output logic                  resetmux,
  output logic                  adc_measure_valid,
  output adc_pkg::conv_result_t conv_result
);

  adc_pkg::conv_state_t state;

  // integrator sign taken at end of integration, high when positive
  logic sign_pos;
  // comparator has moved away from the latched sign
  logic crossed;
  // last cycle of run-down, either crossing or limit
  logic rundown_end;

  assign crossed     = (cmpr_in != sign_pos);
  assign rundown_end = crossed || expired;

  ////////////////////////////////////////////////////////////////////////////
  // timer control

  // combinational so the timer takes the new phase on the same edge as the state.
  // each phase loads its length minus one, the zero count is the last clock
  always_comb
  begin
    timer_load  = 1'b0;
    timer_value = adc_pkg::RESET_CLKS - 32'd1;
    if (adc_measure_trig)
    begin
      // restart from any state
      timer_load = 1'b1;
    end
    else if (state == adc_pkg::CONV_RESET && expired)
    begin
      // duration of zero is not supported, it would wrap
      timer_load  = 1'b1;
      timer_value = clk_sample_duration - 32'd1;
    end
    else if (state == adc_pkg::CONV_SIGNAL && expired)
    begin
      timer_load  = 1'b1;
      timer_value = adc_pkg::RUNDOWN_MAX - 32'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and analog switches

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state             <= adc_pkg::CONV_IDLE;
      sign_pos          <= 1'b0;
      cmpr_latch        <= 1'b0;
      refmux            <= adc_pkg::REF_OFF;
      sigmux            <= 1'b0;
      resetmux          <= 1'b0;
      adc_measure_valid <= 1'b0;
    end
    else if (adc_measure_trig)
    begin
      // interrupt whatever runs and short the integrator
      state             <= adc_pkg::CONV_RESET;
      adc_measure_valid <= 1'b0;
      cmpr_latch        <= 1'b0;
      refmux            <= adc_pkg::REF_OFF;
      sigmux            <= 1'b0;
      resetmux          <= 1'b1;
    end
    else
    begin
      case (state)
        adc_pkg::CONV_RESET:
        begin
          if (expired)
          begin
            // release reset, connect input
            state    <= adc_pkg::CONV_SIGNAL;
            resetmux <= 1'b0;
            sigmux   <= 1'b1;
          end
        end

        adc_pkg::CONV_SIGNAL:
        begin
          if (expired)
          begin
            // latch sign and pick the reference that drives charge back to zero
            state      <= adc_pkg::CONV_RUNDOWN;
            sigmux     <= 1'b0;
            sign_pos   <= cmpr_in;
            cmpr_latch <= 1'b1;
            refmux     <= cmpr_in ? adc_pkg::REF_NEG : adc_pkg::REF_POS;
          end
        end

        adc_pkg::CONV_RUNDOWN:
        begin
          if (rundown_end)
          begin
            state             <= adc_pkg::CONV_DONE;
            refmux            <= adc_pkg::REF_OFF;
            cmpr_latch        <= 1'b0;
            adc_measure_valid <= 1'b1;
          end
        end

        // idle and done hold until the next trigger
        default:
        begin
          state <= state;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // result capture

  // written once at the end of run-down, stable while valid is high
  always_ff @(posedge clk)
  begin
    if (!adc_measure_trig && state == adc_pkg::CONV_RUNDOWN && rundown_end)
    begin
      // clocks of reference current before the crossing was seen
      conv_result.rundown_count <= (adc_pkg::RUNDOWN_MAX - 32'd1) - remaining;
      conv_result.negative      <= !sign_pos;
      conv_result.overrange     <= expired && !crossed;
    end
  end

endmodule

// ==== rtl/adc_frontend_top.sv ====
/* adc front end top: conversion controller, phase timer, auto-zero
   sequencer and result registers, with a registered monitor bus */

`timescale 1ns/1ps

module adc_frontend_top (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            run,
  input  adc_pkg::count_t                 clk_sample_duration,
  input  logic                            cmpr_in,
  output logic                            cmpr_latch,
  output adc_pkg::refmux_t                refmux,
  output logic                            sigmux,
  output logic                            resetmux,
  output adc_pkg::az_phase_t              az_mux,
  output adc_pkg::reading_t               reading,
  output logic                            reading_valid,
  output logic                            overrange,
  output logic [adc_pkg::MONITOR_W-1:0]   monitor
);

  // sequencer and controller handshake
  logic                  adc_measure_trig;
  logic                  adc_measure_valid;
  adc_pkg::conv_result_t conv_result;
  // timer link
  logic                  timer_load;
  adc_pkg::count_t       timer_value;
  adc_pkg::count_t       remaining;
  logic                  expired;
  // result filing
  logic                  store;
  adc_pkg::az_phase_t    store_phase;

  adc_phase_timer i_adc_phase_timer (
    .clk        (clk),
    .reset      (reset),
    .load       (timer_load),
    .load_value (timer_value),
    .remaining  (remaining),
    .expired    (expired)
  );

  adc_conv_fsm i_adc_conv_fsm (
    .clk                 (clk),
    .reset               (reset),
    .clk_sample_duration (clk_sample_duration),
    .adc_measure_trig    (adc_measure_trig),
    .cmpr_in             (cmpr_in),
    .remaining           (remaining),
    .expired             (expired),
    .timer_load          (timer_load),
    .timer_value         (timer_value),
    .cmpr_latch          (cmpr_latch),
    .refmux              (refmux),
    .sigmux              (sigmux),
    .resetmux            (resetmux),
    .adc_measure_valid   (adc_measure_valid),
    .conv_result         (conv_result)
  );

  az_sequencer i_az_sequencer (
    .clk               (clk),
    .reset             (reset),
    .run               (run),
    .adc_measure_valid (adc_measure_valid),
    .adc_measure_trig  (adc_measure_trig),
    .az_mux            (az_mux),
    .store             (store),
    .store_phase       (store_phase)
  );

  az_result_regs i_az_result_regs (
    .clk           (clk),
    .reset         (reset),
    .store         (store),
    .store_phase   (store_phase),
    .conv_result   (conv_result),
    .reading       (reading),
    .reading_valid (reading_valid),
    .overrange     (overrange)
  );

  ////////////////////////////////////////////////////////////////////////////
  // monitor bus, every bit one clock behind its source

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      monitor <= '0;
    end
    else
    begin
      // bit 0 trigger up to bit 5 comparator latch
      monitor <= {cmpr_latch, sigmux, resetmux, az_mux, adc_measure_valid, adc_measure_trig};
    end
  end

endmodule

// ==== rtl/adc_phase_timer.sv ====
/* phase timer: loadable down-counter for the conversion phases,
   holds at zero and flags it */

`timescale 1ns/1ps

module adc_phase_timer (
  input  logic            clk,
  input  logic            reset,
  input  logic            load,
  input  adc_pkg::count_t load_value,
  output adc_pkg::count_t remaining,
  output logic            expired
);

  // a load of n gives n+1 cycles before the count leaves zero,
  // the fsm loads phase length minus one for that reason
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      remaining <= '0;
    end
    else if (load)
    begin
      // load wins over the decrement
      remaining <= load_value;
    end
    else if (remaining != '0)
    begin
      // count down and park at zero, no wrap
      remaining <= remaining - 32'd1;
    end
  end

  // level, high for as long as the count sits at zero
  assign expired = (remaining == '0);

endmodule

// ==== rtl/adc_pkg.sv ====
/* adc front end package: widths, switch encodings, FSM states,
   phase timing and the conversion result record */

package adc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths with a meaning

  // phase length or clock count, unsigned
  typedef logic [31:0] count_t;

  // auto-zeroed reading, signed hi minus lo
  typedef logic signed [32:0] reading_t;

  // reference current selection into the integrator
  typedef logic [1:0] refmux_t;

  // switch encodings for refmux_t
  localparam refmux_t REF_OFF = 2'b00;
  // sinks charge, used to discharge a positive integrator
  localparam refmux_t REF_NEG = 2'b01;
  localparam refmux_t REF_POS = 2'b10;

  ////////////////////////////////////////////////////////////////////////////
  // state machines and sample phase

  typedef enum logic [2:0] {
    CONV_IDLE,
    CONV_RESET,
    CONV_SIGNAL,
    CONV_RUNDOWN,
    CONV_DONE
  } conv_state_t;

  typedef enum logic [1:0] {
    AZ_IDLE,
    AZ_TRIG,
    AZ_WAIT,
    AZ_STORE
  } az_state_t;

  // hi selects the input, lo selects the zero
  typedef enum logic {
    AZ_LO = 1'b0,
    AZ_HI = 1'b1
  } az_phase_t;

  ////////////////////////////////////////////////////////////////////////////
  // conversion result and timing

  typedef struct packed {
    count_t rundown_count;
    // integrator below zero at end of integration
    logic   negative;
    // comparator never crossed within the run-down limit
    logic   overrange;
  } conv_result_t;

  // integrator reset phase length in clocks
  localparam count_t RESET_CLKS = 32'd8;
  // run-down limit in clocks
  localparam count_t RUNDOWN_MAX = 32'd4096;
  // monitor bus width
  localparam int MONITOR_W = 6;

endpackage

// ==== rtl/az_result_regs.sv ====
/* auto-zero result registers: keep signed hi and lo conversions
   and publish hi minus lo after each complete pair */

`timescale 1ns/1ps

module az_result_regs (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  store,
  input  adc_pkg::az_phase_t    store_phase,
  input  adc_pkg::conv_result_t conv_result,
  output adc_pkg::reading_t     reading,
  output logic                  reading_valid,
  output logic                  overrange
);

  // signed form of the incoming result
  adc_pkg::reading_t conv_signed;
  adc_pkg::reading_t magnitude;
  adc_pkg::reading_t hi_val;
  adc_pkg::reading_t lo_val;
  // hi stored since the last reading
  logic hi_seen;
  logic hi_over;
  logic lo_over;

  // zero-extend the count, then apply the integrator sign
  assign magnitude   = adc_pkg::reading_t'({1'b0, conv_result.rundown_count});
  assign conv_signed = conv_result.negative ? -magnitude : magnitude;

  // sample registers
  always_ff @(posedge clk)
  begin
    if (store && store_phase == adc_pkg::AZ_HI)
    begin
      hi_val <= conv_signed;
    end
    if (store && store_phase == adc_pkg::AZ_LO)
    begin
      lo_val <= conv_signed;
    end
  end

  // pairing and flags
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      hi_seen       <= 1'b0;
      hi_over       <= 1'b0;
      lo_over       <= 1'b0;
      reading_valid <= 1'b0;
    end
    else
    begin
      reading_valid <= 1'b0;
      if (store && store_phase == adc_pkg::AZ_HI)
      begin
        hi_seen <= 1'b1;
        hi_over <= conv_result.overrange;
      end
      else if (store && store_phase == adc_pkg::AZ_LO)
      begin
        lo_over <= conv_result.overrange;
        // a lone lo after idle gives no reading
        reading_valid <= hi_seen;
        hi_seen       <= 1'b0;
      end
    end
  end

  // valid the cycle after the lo store, when lo_val has just updated
  assign reading   = hi_val - lo_val;
  assign overrange = hi_over || lo_over;

endmodule

// ==== rtl/az_sequencer.sv ====
/* auto-zero sequencer: alternates input and zero conversions,
   triggers the conversion controller and files each result */

`timescale 1ns/1ps

module az_sequencer (
  input  logic               clk,
  input  logic               reset,
  input  logic               run,
  input  logic               adc_measure_valid,
  output logic               adc_measure_trig,
  output adc_pkg::az_phase_t az_mux,
  output logic               store,
  output adc_pkg::az_phase_t store_phase
);

  adc_pkg::az_state_t state;
  // phase of the conversion being taken or about to be triggered
  adc_pkg::az_phase_t phase;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state  <= adc_pkg::AZ_IDLE;
      phase  <= adc_pkg::AZ_HI;
      az_mux <= adc_pkg::AZ_HI;
    end
    else
    begin
      case (state)
        adc_pkg::AZ_IDLE:
        begin
          // every run starts on the input sample
          phase <= adc_pkg::AZ_HI;
          if (run)
          begin
            state <= adc_pkg::AZ_TRIG;
          end
        end

        adc_pkg::AZ_TRIG:
        begin
          // input mux moves with the trigger, settles during integrator reset
          az_mux <= phase;
          state  <= adc_pkg::AZ_WAIT;
        end

        adc_pkg::AZ_WAIT:
        begin
          // controller cleared valid at the trigger edge
          if (adc_measure_valid)
          begin
            state <= adc_pkg::AZ_STORE;
          end
        end

        adc_pkg::AZ_STORE:
        begin
          phase <= (phase == adc_pkg::AZ_HI) ? adc_pkg::AZ_LO : adc_pkg::AZ_HI;
          // run low lets the finished conversion land, then stop
          if (run)
          begin
            state <= adc_pkg::AZ_TRIG;
          end
          else
          begin
            state <= adc_pkg::AZ_IDLE;
          end
        end

        default:
        begin
          state <= adc_pkg::AZ_IDLE;
        end
      endcase
    end
  end

  // one-cycle strobes decoded from state
  assign adc_measure_trig = (state == adc_pkg::AZ_TRIG);
  assign store            = (state == adc_pkg::AZ_STORE);

  // phase flips only after the store, so it still names the finished result
  assign store_phase = phase;

endmodule

// ==== verification/tb_adc_frontend.sv ====
/* adc front end testbench: integrator and comparator model, random
   levels, switch sequence and monitor checks, auto-zeroed reading compare */

`timescale 1ns/1ps

module tb_adc_frontend;

  localparam int CLK_PERIOD  = 20;
  // charge removed or added per clock of reference current
  localparam int REF_STEP    = 64;
  localparam int NUM_TESTS   = 12;
  // one test drives a level that cannot run down in time
  localparam int OVER_TEST   = 5;
  localparam int OVER_LEVEL  = 20000;
  localparam int RESET_LEN   = int'(adc_pkg::RESET_CLKS);
  localparam int RUNDOWN_LEN = int'(adc_pkg::RUNDOWN_MAX);
  // longest single conversion with the largest duration
  localparam int CONV_MAX    = RESET_LEN + 255 + RUNDOWN_LEN + 10;
  localparam int WATCHDOG_CLKS = NUM_TESTS * 2 * CONV_MAX;

  logic                          clk;
  logic                          reset;
  logic                          run;
  adc_pkg::count_t               clk_sample_duration;
  logic                          cmpr_in;
  logic                          cmpr_latch;
  adc_pkg::refmux_t              refmux;
  logic                          sigmux;
  logic                          resetmux;
  adc_pkg::az_phase_t            az_mux;
  adc_pkg::reading_t             reading;
  logic                          reading_valid;
  logic                          overrange;
  logic [adc_pkg::MONITOR_W-1:0] monitor;

  // analog side and stimulus state
  int          hi_level;
  int          lo_level;
  int          charge;
  logic [31:0] lfsr_state;
  // switch state seen last cycle, acts on the integrator one clock later
  logic               held_resetmux;
  logic               held_sigmux;
  adc_pkg::refmux_t   held_refmux;
  adc_pkg::az_phase_t held_az_mux;

  // expected and observed per test
  longint exp_reading;
  logic   exp_over;
  longint last_reading;
  int     readings_seen;
  int     trig_count;
  adc_pkg::az_phase_t az_seq[$];
  int     rd_lens[$];

  // switch checker history
  logic               prev_resetmux;
  logic               prev_sigmux;
  adc_pkg::refmux_t   prev_refmux;
  adc_pkg::az_phase_t prev_az_mux;
  logic               prev_cmpr_latch;
  logic               valid_model;
  logic               trig_now;
  int                 reset_len;
  int                 sig_len;
  int                 rd_len;
  int                 active;

  int errors;
  int tests_run;
  int tests_failed;

  adc_frontend_top i_adc_frontend_top (
    .clk                 (clk),
    .reset               (reset),
    .run                 (run),
    .clk_sample_duration (clk_sample_duration),
    .cmpr_in             (cmpr_in),
    .cmpr_latch          (cmpr_latch),
    .refmux              (refmux),
    .sigmux              (sigmux),
    .resetmux            (resetmux),
    .az_mux              (az_mux),
    .reading             (reading),
    .reading_valid       (reading_valid),
    .overrange           (overrange),
    .monitor             (monitor)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  // galois step, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
    begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int k = 0; k < n; k++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | int'(lfsr_state[0]);
    end
  endtask

  // signed count of one conversion, ceiling of |duration*level| in steps
  function automatic int expected_count(input int duration, input int level, output logic over);
    int total;
    int mag;
    int cnt;
    total = duration * level;
    mag   = (total < 0) ? -total : total;
    cnt   = (mag + REF_STEP - 1) / REF_STEP;
    // limit reached, count saturates at the last run-down clock
    over  = (cnt > RUNDOWN_LEN - 1);
    if (over)
    begin
      cnt = RUNDOWN_LEN - 1;
    end
    return (total < 0) ? -cnt : cnt;
  endfunction

  task automatic report_value(input string name, input longint expected, input longint actual);
    errors++;
    $display("ERROR t=%0t %s: expected %0d got %0d", $time, name, expected, actual);
  endtask

  task automatic report_fault(input string msg);
    errors++;
    $display("t=%0t %s", $time, msg);
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // clock, watchdog, integrator

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    repeat (WATCHDOG_CLKS) @(posedge clk);
    abort_run("watchdog expired before the tests finished");
  end

  // charge follows last cycle's switches, comparator high above zero
  initial
  begin
    charge        = 0;
    cmpr_in       = 1'b0;
    held_resetmux = 1'b0;
    held_sigmux   = 1'b0;
    held_refmux   = adc_pkg::REF_OFF;
    held_az_mux   = adc_pkg::AZ_HI;
    forever
    begin
      @(posedge clk);
      #2;
      if (held_resetmux)
      begin
        charge = 0;
      end
      else
      begin
        if (held_sigmux)
        begin
          charge += (held_az_mux == adc_pkg::AZ_HI) ? hi_level : lo_level;
        end
        if (held_refmux == adc_pkg::REF_NEG)
        begin
          charge -= REF_STEP;
        end
        else if (held_refmux == adc_pkg::REF_POS)
        begin
          charge += REF_STEP;
        end
      end
      cmpr_in       = (charge > 0);
      held_resetmux = resetmux;
      held_sigmux   = sigmux;
      held_refmux   = refmux;
      held_az_mux   = az_mux;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // switch sequence and monitor checker

  initial
  begin
    @(negedge reset);
    repeat (2) @(posedge clk);
    #5;
    valid_model     = 1'b0;
    reset_len       = 0;
    sig_len         = 0;
    rd_len          = 0;
    prev_resetmux   = resetmux;
    prev_sigmux     = sigmux;
    prev_refmux     = refmux;
    prev_az_mux     = az_mux;
    prev_cmpr_latch = cmpr_latch;
    forever
    begin
      @(posedge clk);
      #5;
      active = int'(resetmux) + int'(sigmux) + int'(refmux != adc_pkg::REF_OFF);
      if (active > 1)
      begin
        report_fault("more than one integrator switch active");
      end
      if (refmux == 2'b11)
      begin
        report_fault("both reference switches closed");
      end
      if (cmpr_latch !== (refmux != adc_pkg::REF_OFF))
      begin
        report_value("cmpr_latch", refmux != adc_pkg::REF_OFF, cmpr_latch);
      end
      // a trigger shows as resetmux rising on the next cycle
      trig_now = resetmux && !prev_resetmux;
      if (monitor[0] !== trig_now)
      begin
        report_value("monitor[0]", trig_now, monitor[0]);
      end
      if (monitor[1] !== valid_model)
      begin
        report_value("monitor[1]", valid_model, monitor[1]);
      end
      if (monitor[2] !== prev_az_mux)
      begin
        report_value("monitor[2]", prev_az_mux, monitor[2]);
      end
      if (monitor[3] !== prev_resetmux)
      begin
        report_value("monitor[3]", prev_resetmux, monitor[3]);
      end
      if (monitor[4] !== prev_sigmux)
      begin
        report_value("monitor[4]", prev_sigmux, monitor[4]);
      end
      if (monitor[5] !== prev_cmpr_latch)
      begin
        report_value("monitor[5]", prev_cmpr_latch, monitor[5]);
      end
      // valid drops at the trigger, rises when the reference opens
      if (trig_now)
      begin
        valid_model = 1'b0;
        trig_count++;
        az_seq.push_back(az_mux);
      end
      else if (prev_refmux != adc_pkg::REF_OFF && refmux == adc_pkg::REF_OFF)
      begin
        valid_model = 1'b1;
      end
      if (resetmux)
      begin
        reset_len++;
      end
      else if (prev_resetmux)
      begin
        if (reset_len != RESET_LEN)
        begin
          report_value("resetmux cycles", RESET_LEN, reset_len);
        end
        if (!sigmux)
        begin
          report_fault("sigmux did not follow the integrator reset");
        end
        reset_len = 0;
      end
      if (sigmux)
      begin
        sig_len++;
      end
      else if (prev_sigmux)
      begin
        if (sig_len != int'(clk_sample_duration))
        begin
          report_value("sigmux cycles", clk_sample_duration, sig_len);
        end
        if (refmux == adc_pkg::REF_OFF)
        begin
          report_fault("run-down did not follow signal integration");
        end
        sig_len = 0;
      end
      if (refmux != adc_pkg::REF_OFF)
      begin
        // reference must drive the charge back toward zero
        if (prev_refmux == adc_pkg::REF_OFF)
        begin
          if (refmux !== ((charge > 0) ? adc_pkg::REF_NEG : adc_pkg::REF_POS))
          begin
            report_value("refmux", (charge > 0) ? adc_pkg::REF_NEG : adc_pkg::REF_POS, refmux);
          end
        end
        rd_len++;
      end
      else if (prev_refmux != adc_pkg::REF_OFF)
      begin
        rd_lens.push_back(rd_len);
        rd_len = 0;
      end
      prev_resetmux   = resetmux;
      prev_sigmux     = sigmux;
      prev_refmux     = refmux;
      prev_az_mux     = az_mux;
      prev_cmpr_latch = cmpr_latch;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reading compare, one count of slack at the comparator crossing

  initial
  begin
    longint diff;
    forever
    begin
      @(posedge clk);
      #5;
      if (!reset && reading_valid === 1'b1)
      begin
        readings_seen++;
        last_reading = reading;
        diff = last_reading - exp_reading;
        if (diff > 1 || diff < -1)
        begin
          report_value("reading", exp_reading, last_reading);
        end
        if (overrange !== exp_over)
        begin
          report_value("overrange", exp_over, overrange);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests

  task automatic check_idle();
    int err_before;
    err_before = errors;
    @(posedge clk);
    #5;
    if (resetmux !== 1'b0)
    begin
      report_value("resetmux", 0, resetmux);
    end
    if (sigmux !== 1'b0)
    begin
      report_value("sigmux", 0, sigmux);
    end
    if (refmux !== adc_pkg::REF_OFF)
    begin
      report_value("refmux", adc_pkg::REF_OFF, refmux);
    end
    if (cmpr_latch !== 1'b0)
    begin
      report_value("cmpr_latch", 0, cmpr_latch);
    end
    if (reading_valid !== 1'b0)
    begin
      report_value("reading_valid", 0, reading_valid);
    end
    if (overrange !== 1'b0)
    begin
      report_value("overrange", 0, overrange);
    end
    tests_run++;
    if (errors != err_before)
    begin
      tests_failed++;
    end
    $display("idle after reset: %s", (errors == err_before) ? "ok" : "FAIL");
  endtask

  // hi, lo, then run drops while a third conversion is in flight
  task automatic run_test(input int idx, input int hi, input int lo, input int dur);
    int   err_before;
    int   hi_cnt;
    int   lo_cnt;
    logic hi_over;
    logic lo_over;
    int   waited;
    err_before = errors;
    hi_cnt = expected_count(dur, hi, hi_over);
    lo_cnt = expected_count(dur, lo, lo_over);
    @(posedge clk);
    #2;
    exp_reading   = hi_cnt - lo_cnt;
    exp_over      = hi_over || lo_over;
    readings_seen = 0;
    trig_count    = 0;
    az_seq.delete();
    rd_lens.delete();
    hi_level            = hi;
    lo_level            = lo;
    clk_sample_duration = adc_pkg::count_t'(dur);
    run                 = 1'b1;
    waited = 0;
    while (readings_seen == 0)
    begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > 2 * CONV_MAX)
      begin
        abort_run("no reading_valid pulse within two conversion times");
      end
    end
    run = 1'b0;
    waited = 0;
    while (rd_lens.size() < 3)
    begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > CONV_MAX)
      begin
        abort_run("conversion in flight did not finish after run dropped");
      end
    end
    // sequencer must stay idle from here on
    repeat (20) @(posedge clk);
    if (trig_count != 3)
    begin
      report_value("trigger count", 3, trig_count);
    end
    if (readings_seen != 1)
    begin
      report_value("reading_valid pulses", 1, readings_seen);
    end
    if (az_seq.size() == 3)
    begin
      if (az_seq[0] != adc_pkg::AZ_HI || az_seq[1] != adc_pkg::AZ_LO
          || az_seq[2] != adc_pkg::AZ_HI)
      begin
        report_fault("az_mux did not alternate hi, lo, hi");
      end
    end
    if (hi_over && rd_lens[0] != RUNDOWN_LEN)
    begin
      report_value("overrange run-down cycles", RUNDOWN_LEN, rd_lens[0]);
    end
    tests_run++;
    if (errors != err_before)
    begin
      tests_failed++;
    end
    $display("test %0d: hi %0d lo %0d duration %0d reading %0d expected %0d %s",
             idx, hi, lo, dur, last_reading, exp_reading,
             (errors == err_before) ? "ok" : "FAIL");
  endtask

  initial
  begin
    int mag;
    int lo_mag;
    int lo_sign;
    int d;
    int hi;
    int lo;
    int dur;
    reset               = 1'b1;
    run                 = 1'b0;
    clk_sample_duration = adc_pkg::count_t'(16);
    hi_level            = 0;
    lo_level            = 0;
    exp_reading         = 0;
    exp_over            = 1'b0;
    last_reading        = 0;
    readings_seen       = 0;
    trig_count          = 0;
    errors              = 0;
    tests_run           = 0;
    tests_failed        = 0;
    lfsr_state          = 32'd88611;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    check_idle();
    for (int i = 0; i < NUM_TESTS; i++)
    begin
      draw_bits(9, mag);
      draw_bits(6, lo_mag);
      draw_bits(1, lo_sign);
      draw_bits(8, d);
      dur = 16 + (d % 240);
      // hi sign alternates so both polarities run
      hi = (i % 2 == 1) ? -mag : mag;
      if (i == OVER_TEST)
      begin
        hi = OVER_LEVEL;
      end
      lo = (lo_sign == 1) ? -lo_mag : lo_mag;
      run_test(i, hi, lo, dur);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
